// ==== hdl/song_pkg.sv ====
`default_nettype none

// --------------------------------------------------
// song memory layout and word format
// --------------------------------------------------
package song_pkg;

    // the memory is split into equal slots, one per song
    localparam int num_songs  = 4;
    localparam int song_words = 32;
    localparam int mem_words  = num_songs * song_words;

    // selects which of the four songs is played
    typedef logic [$clog2(num_songs)-1:0] song_id_t;

    // word index inside one song
    typedef logic [$clog2(song_words)-1:0] step_t;

    // song id sits above the step so each song owns a contiguous block
    typedef logic [6:0] mem_addr_t;

    // one 16-bit song word, most significant field first
    // for a rest word the duration field carries the rest length in beats
    // and a rest of zero beats marks the end of the song
    typedef struct packed {
        logic       is_rest;
        logic [5:0] note;
        logic [5:0] duration;
        logic [2:0] options;
    } song_word_t;

    // --------------------------------------------------
    // sequencer states
    // --------------------------------------------------
    // paused waits for play, fetch presents the address, decode acts on
    // the returned word, rest waits on the rest timer and advance steps on
    typedef enum logic [2:0] {
        paused,
        fetch,
        decode,
        rest,
        advance
    } seq_state_t;

endpackage

`default_nettype wire

// ==== hdl/voice_pkg.sv ====
`default_nettype none

// --------------------------------------------------
// voice side definitions
// --------------------------------------------------
package voice_pkg;

    // three voices can sound at once
    localparam int num_voices  = 3;

    // clock cycles per beat, kept tiny so runs stay short
    localparam int beat_cycles = 4;

    // a duration field of zero stands for this many beats
    localparam int max_beats   = 64;

    // pitch index handed on to the tone generator
    typedef logic [5:0] note_t;

    // length of a note or rest in beats
    typedef logic [5:0] duration_t;

    // length in cycles, wide enough for max_beats times beat_cycles
    typedef logic [8:0] tick_t;

    // what the sequencer hands to one voice
    typedef struct packed {
        note_t     note;
        duration_t duration;
    } voice_cmd_t;

    // what one voice reports to the mixer
    typedef struct packed {
        logic  active;
        note_t note;
    } voice_out_t;

endpackage

`default_nettype wire

// ==== hdl/song_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

// --------------------------------------------------
// song memory, one write port and one read port
// --------------------------------------------------
module song_ram (
    input  logic                 clk,
    input  logic                 wr_en,
    input  song_pkg::mem_addr_t  wr_addr,
    input  song_pkg::song_word_t wr_data,
    input  song_pkg::mem_addr_t  rd_addr,
    output song_pkg::song_word_t rd_data
);
    import song_pkg::*;

    // four songs of 32 words each
    song_word_t mem [mem_words];

    // the host loads songs through a plain strobe
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, the word shows up one cycle after its address
    // holding the address keeps the same word on rd_data
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== hdl/rest_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

// --------------------------------------------------
// rest timer, counts a rest out in clock cycles
// --------------------------------------------------
module rest_timer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 rest_load,
    input  voice_pkg::duration_t rest_len,
    output logic                 rest_done
);
    import voice_pkg::*;

    // cycles left in the current rest
    tick_t count_q;

    // rest length converted from beats to cycles
    tick_t rest_ticks;

    // the sequencer only deals in beats, the scaling lives here
    assign rest_ticks = tick_t'(rest_len) * tick_t'(beat_cycles);

    // a load restarts the count even if a rest is still running
    // otherwise the count runs down and parks at zero
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (rest_load) begin
            count_q <= rest_ticks;
        end else if (count_q != '0) begin
            count_q <= count_q - tick_t'(1);
        end
    end

    // high whenever no rest is pending
    // it drops the cycle after a load and rises again rest_ticks later
    assign rest_done = (count_q == '0);

endmodule

`default_nettype wire

// ==== hdl/note_player.sv ====
`timescale 1ns/1ps
`default_nettype none

// --------------------------------------------------
// one voice, plays a single note for its length
// --------------------------------------------------
module note_player (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  note_load,
    input  voice_pkg::voice_cmd_t note_cmd,
    output logic                  busy,
    output logic                  voice_start,
    output voice_pkg::voice_out_t voice
);
    import voice_pkg::*;

    // cycles left for the note that is sounding
    tick_t count_q;

    // note being played, zero when idle
    note_t note_q;

    // registered copy of the load strobe
    logic start_q;

    // a duration field of zero means the longest note
    logic [6:0] beats;
    tick_t      note_ticks;

    assign beats      = (note_cmd.duration == '0) ? 7'(max_beats) : {1'b0, note_cmd.duration};
    assign note_ticks = tick_t'(beats) * tick_t'(beat_cycles);

    // count_q reaches note_ticks on the cycle after the load, then counts down
    // the last active cycle is the one where the count equals one
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count_q <= '0;
            note_q  <= '0;
            start_q <= 1'b0;
        end else begin
            start_q <= note_load;
            if (note_load) begin
                count_q <= note_ticks;
                note_q  <= note_cmd.note;
            end else if (count_q != '0) begin
                count_q <= count_q - tick_t'(1);
                // clear the note as the voice goes idle
                if (count_q == tick_t'(1)) begin
                    note_q <= '0;
                end
            end
        end
    end

    // busy falls right after the last active cycle so the voice can be reused
    assign busy         = (count_q != '0);
    assign voice_start  = start_q;
    assign voice.active = busy;
    assign voice.note   = note_q;

endmodule

`default_nettype wire

// ==== hdl/song_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

// --------------------------------------------------
// song sequencer, walks one song word by word
// --------------------------------------------------
module song_sequencer (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             play,
    input  song_pkg::song_id_t               song_sel,
    output song_pkg::mem_addr_t              rd_addr,
    input  song_pkg::song_word_t             rd_data,
    input  logic [voice_pkg::num_voices-1:0] voice_busy,
    output logic [voice_pkg::num_voices-1:0] note_load,
    output voice_pkg::voice_cmd_t            note_cmd,
    output logic                             rest_load,
    output voice_pkg::duration_t             rest_len,
    input  logic                             rest_done,
    output logic                             playing,
    output logic                             song_done
);
    import song_pkg::*;
    import voice_pkg::*;

    seq_state_t state_q;
    seq_state_t state_d;

    // position inside the song, kept across a pause
    step_t step_q;
    step_t step_d;

    // song latched when playback starts
    song_id_t song_q;

    // set by song_done, held until play goes low
    logic done_lock_q;

    // step plus one with the overflow bit on top
    logic [$bits(step_t):0] step_inc;

    // one-hot pick of the lowest free voice, zero when all are busy
    logic [num_voices-1:0] free_pick;

    // rest word with zero length
    logic is_end;

    // --------------------------------------------------
    // word decode and voice choice
    // --------------------------------------------------
    assign rd_addr  = {song_q, step_q};
    assign step_inc = {1'b0, step_q} + ($bits(step_t) + 1)'(1);
    assign is_end   = rd_data.is_rest && (rd_data.duration == '0);

    // the rest length is the duration field of a rest word
    assign rest_len          = rd_data.duration;
    assign note_cmd.note     = rd_data.note;
    assign note_cmd.duration = rd_data.duration;

    // scan from the top so the lowest free voice is the one left standing
    always_comb begin
        free_pick = '0;
        for (int i = num_voices - 1; i >= 0; i--) begin
            if (!voice_busy[i]) begin
                free_pick    = '0;
                free_pick[i] = 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // next state and strobes
    // --------------------------------------------------
    always_comb begin
        state_d   = state_q;
        step_d    = step_q;
        note_load = '0;
        rest_load = 1'b0;
        song_done = 1'b0;
        case (state_q)
            paused: begin
                // a finished song needs play to drop before it restarts
                if (play && !done_lock_q) begin
                    state_d = fetch;
                end
            end
            fetch: begin
                state_d = play ? decode : paused;
            end
            decode: begin
                if (!play) begin
                    state_d = paused;
                end else if (!rd_data.is_rest) begin
                    // with every voice busy we sit here until one frees
                    if (free_pick != '0) begin
                        note_load = free_pick;
                        state_d   = advance;
                    end
                end else if (is_end) begin
                    song_done = 1'b1;
                    step_d    = '0;
                    state_d   = paused;
                end else begin
                    rest_load = 1'b1;
                    state_d   = rest;
                end
            end
            rest: begin
                // rest_done is low the cycle we arrive since the timer just loaded
                if (!play) begin
                    state_d = paused;
                end else if (rest_done) begin
                    state_d = advance;
                end
            end
            advance: begin
                // runs to completion whatever play does
                if (step_inc[$bits(step_t)]) begin
                    song_done = 1'b1;
                    step_d    = '0;
                    state_d   = paused;
                end else begin
                    step_d  = step_inc[$bits(step_t)-1:0];
                    state_d = play ? fetch : paused;
                end
            end
            default: begin
                state_d = paused;
            end
        endcase
    end

    // --------------------------------------------------
    // registers
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q     <= paused;
            step_q      <= '0;
            song_q      <= '0;
            done_lock_q <= 1'b0;
        end else begin
            state_q <= state_d;
            step_q  <= step_d;
            // song_sel only matters on the way out of paused
            if (state_q == paused && state_d == fetch) begin
                song_q <= song_sel;
            end
            if (song_done) begin
                done_lock_q <= 1'b1;
            end else if (!play) begin
                done_lock_q <= 1'b0;
            end
        end
    end

    assign playing = (state_q != paused);

endmodule

`default_nettype wire

// ==== hdl/song_player_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// --------------------------------------------------
// song playback top level
// --------------------------------------------------
module song_player_top (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  logic                                              play,
    input  song_pkg::song_id_t                                song_sel,
    input  logic                                              wr_en,
    input  song_pkg::mem_addr_t                               wr_addr,
    input  song_pkg::song_word_t                              wr_data,
    output voice_pkg::voice_out_t [voice_pkg::num_voices-1:0] voices,
    output logic [voice_pkg::num_voices-1:0]                  voice_start,
    output logic                                              playing,
    output logic                                              song_done
);
    import song_pkg::*;
    import voice_pkg::*;

    // memory read path
    mem_addr_t  rd_addr;
    song_word_t rd_data;

    // sequencer to voices
    logic [num_voices-1:0] voice_busy;
    logic [num_voices-1:0] note_load;
    voice_cmd_t            note_cmd;

    // sequencer to rest timer
    logic      rest_load;
    duration_t rest_len;
    logic      rest_done;

    song_ram u_ram (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    song_sequencer u_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .play       (play),
        .song_sel   (song_sel),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .voice_busy (voice_busy),
        .note_load  (note_load),
        .note_cmd   (note_cmd),
        .rest_load  (rest_load),
        .rest_len   (rest_len),
        .rest_done  (rest_done),
        .playing    (playing),
        .song_done  (song_done)
    );

    rest_timer u_rest (
        .clk       (clk),
        .rst_n     (rst_n),
        .rest_load (rest_load),
        .rest_len  (rest_len),
        .rest_done (rest_done)
    );

    // all voices see the same command, note_load says which one takes it
    for (genvar v = 0; v < num_voices; v++) begin : g_voice
        note_player u_voice (
            .clk         (clk),
            .rst_n       (rst_n),
            .note_load   (note_load[v]),
            .note_cmd    (note_cmd),
            .busy        (voice_busy[v]),
            .voice_start (voice_start[v]),
            .voice       (voices[v])
        );
    end

endmodule

`default_nettype wire

// ==== bench/tb_song_player.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_song_player;
    import song_pkg::*;
    import voice_pkg::*;

    logic                        clk;
    logic                        rst_n;
    logic                        play;
    song_id_t                    song_sel;
    logic                        wr_en;
    mem_addr_t                   wr_addr;
    song_word_t                  wr_data;
    voice_out_t [num_voices-1:0] voices;
    logic [num_voices-1:0]       voice_start;
    logic                        playing;
    logic                        song_done;

    // song contents exactly as written into the memory
    song_word_t songs [num_songs][song_words];

    // expected starts, oldest first, with the least gap to the start before
    int exp_note [$];
    int exp_dur [$];
    int exp_gap [$];

    logic [31:0] seed = 32'ha6c4e398;
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int limit = 100000;
    int dones = 0;
    int starts = 0;
    int stalls = 0;

    // per voice model of the note that should be sounding
    int rem [num_voices];
    int cur [num_voices];
    bit was_active [num_voices];
    // cycles since the last start, and whether that gap can be timed
    int since = 0;
    bit timed = 0;
    bit expect_next = 0;
    bit free_now;
    int low_cycles = 0;

    song_player_top u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .play        (play),
        .song_sel    (song_sel),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .voices      (voices),
        .voice_start (voice_start),
        .playing     (playing),
        .song_done   (song_done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // --------------------------------------------------
    // random numbers and the reference model
    // --------------------------------------------------
    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // a number from 0 to n-1 taken from the upper LCG bits
    function automatic int draw(input int n);
        seed = lcg(seed);
        return int'(seed[31:16]) % n;
    endfunction

    // a length in beats turned into cycles, zero beats is the longest note
    function automatic int ticks(input int beats);
        return (beats == 0) ? 64 * 4 : beats * 4;
    endfunction

    // walks one song and queues the notes it should start
    // a note follows the one before after 3 cycles, each rest adds its
    // length plus 4 cycles for the rest word's own fetch and advance
    function automatic int expect_song(input int s);
        int n;
        int gap;
        song_word_t w;
        n = 0;
        gap = 0;
        for (int i = 0; i < song_words; i++) begin
            w = songs[s][i];
            if (w.is_rest && w.duration == '0) begin
                break;
            end
            if (w.is_rest) begin
                gap = gap + 4 + ticks(int'(w.duration));
            end else begin
                exp_note.push_back(int'(w.note));
                exp_dur.push_back(int'(w.duration));
                exp_gap.push_back((n > 0) ? gap : 0);
                n++;
                gap = 3;
            end
        end
        return n;
    endfunction

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------
    // fills every song, the last one has no end marker and overflows
    task automatic build_songs();
        int len;
        int total;
        song_word_t w;
        total = 0;
        for (int s = 0; s < num_songs; s++) begin
            len = (s == num_songs - 1) ? song_words : 6 + draw(15);
            for (int i = 0; i < song_words; i++) begin
                w.note = 6'(draw(64));
                w.options = 3'(draw(8));
                w.is_rest = 1'b0;
                w.duration = 6'(1 + draw(8));
                if (i == len) begin
                    w.is_rest = 1'b1;
                    w.duration = '0;
                end else if (i < len && draw(4) == 0) begin
                    w.is_rest = 1'b1;
                    w.duration = 6'(1 + draw(6));
                end
                // song 1 opens with four long notes so the fourth must wait
                if (s == 1 && i < 4) begin
                    w.is_rest = 1'b0;
                    w.duration = 6'd8;
                end
                // song 2 opens with the longest possible note
                if (s == 2 && i == 0) begin
                    w.is_rest = 1'b0;
                    w.duration = '0;
                end
                songs[s][i] = w;
                if (i < len) begin
                    total = total + 3 + ticks(int'(w.duration));
                end else if (i == len) begin
                    total = total + 3;
                end
            end
        end
        limit = 2 * total + mem_words + 200;
    endtask

    task automatic load_songs();
        for (int a = 0; a < mem_words; a++) begin
            @(posedge clk);
            wr_en <= 1'b1;
            wr_addr <= mem_addr_t'(a);
            wr_data <= songs[a / song_words][a % song_words];
        end
        @(posedge clk);
        wr_en <= 1'b0;
    endtask

    // selects a song while paused, plays it to its end and checks the end
    task automatic play_song(input int s, input bit do_pause);
        int n;
        int d0;
        n = expect_song(s);
        @(posedge clk);
        song_sel <= song_id_t'(s);
        @(posedge clk);
        play <= 1'b1;
        d0 = dones;
        if (do_pause) begin
            repeat (10) @(posedge clk);
            play <= 1'b0;
            repeat (25) @(posedge clk);
            play <= 1'b1;
        end
        while (dones == d0) begin
            @(posedge clk);
        end
        // play stays high here, the song must not start over
        repeat (6) @(posedge clk);
        if (dones != d0 + 1) begin
            errors++;
            $display("Error song_done count expected %h got %h", d0 + 1, dones);
        end
        @(negedge clk);
        if (playing !== 1'b0) begin
            errors++;
            $display("Error playing expected %h got %h", 1'b0, playing);
        end
        if (exp_note.size() != 0) begin
            errors++;
            $display("%0d of %0d notes of song %0d never started", exp_note.size(), n, s);
        end
        @(posedge clk);
        play <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    // --------------------------------------------------
    // monitor, samples at the falling edge
    // --------------------------------------------------
    always @(negedge clk) begin
        if (rst_n) begin
            since = since + 1;
            low_cycles = play ? 0 : low_cycles + 1;
            if (!play) begin
                timed = 1'b0;
            end
            // the sequencer sat in decode with a free voice last cycle
            if (expect_next && voice_start == '0) begin
                errors++;
                $display("a free voice was left unused while a note waited");
            end
            for (int v = 0; v < num_voices; v++) begin
                if (voice_start[v]) begin
                    checks++;
                    starts++;
                    if (was_active[v]) begin
                        errors++;
                        $display("voice %0d started while it was still active", v);
                    end
                    for (int i = 0; i < v; i++) begin
                        if (!was_active[i]) begin
                            errors++;
                            $display("voice %0d started although voice %0d was free", v, i);
                        end
                    end
                    if (exp_note.size() == 0) begin
                        errors++;
                        $display("unexpected start of note %h on voice %0d", voices[v].note, v);
                        rem[v] = 1;
                        cur[v] = int'(voices[v].note);
                    end else begin
                        if (voices[v].note != 6'(exp_note[0])) begin
                            errors++;
                            $display("Error voices[%0d].note expected %h got %h",
                                     v, 6'(exp_note[0]), voices[v].note);
                        end
                        if (timed && exp_gap[0] != 0) begin
                            if (since < exp_gap[0]) begin
                                errors++;
                                $display("Error voice_start gap expected %h got %h",
                                         exp_gap[0], since);
                            end else if (since > exp_gap[0]) begin
                                stalls++;
                            end
                        end
                        rem[v] = ticks(exp_dur[0]);
                        cur[v] = exp_note[0];
                        void'(exp_note.pop_front());
                        void'(exp_dur.pop_front());
                        void'(exp_gap.pop_front());
                    end
                    since = 0;
                    timed = play;
                end
            end
            // every voice follows its own note length
            free_now = 1'b0;
            for (int v = 0; v < num_voices; v++) begin
                checks++;
                if (rem[v] > 0) begin
                    if (voices[v].active !== 1'b1 || voices[v].note != 6'(cur[v])) begin
                        errors++;
                        $display("Error voices[%0d] expected %h got %h",
                                 v, {1'b1, 6'(cur[v])}, voices[v]);
                    end
                    rem[v] = rem[v] - 1;
                end else if (voices[v] !== '0) begin
                    errors++;
                    $display("Error voices[%0d] expected %h got %h", v, 7'h00, voices[v]);
                end
                was_active[v] = voices[v].active;
                free_now = free_now | !voices[v].active;
            end
            if (low_cycles >= 2 && (playing !== 1'b0 || voice_start != '0)) begin
                errors++;
                $display("playback went on while play was low");
            end
            if (song_done) begin
                dones++;
            end
            expect_next = timed && exp_gap.size() > 0 && exp_gap[0] != 0 && play &&
                          since >= exp_gap[0] - 1 && free_now;
        end
    end

    // run length guard
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            errors++;
            $display("timeout after %0d cycles, a song never reached its end", cycles);
            $display("checks %0d  starts %0d  songs %0d  stalls %0d  errors %0d",
                     checks, starts, dones, stalls, errors);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        rst_n = 1'b0;
        play = 1'b0;
        song_sel = '0;
        wr_en = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        for (int v = 0; v < num_voices; v++) begin
            rem[v] = 0;
            cur[v] = 0;
            was_active[v] = 1'b0;
        end
        build_songs();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        checks++;
        if (playing !== 1'b0 || song_done !== 1'b0 || voice_start !== '0 || voices !== '0) begin
            errors++;
            $display("outputs were not idle after reset");
        end
        load_songs();
        // song 0 is paused and resumed midway, song_sel changes before each
        for (int s = 0; s < num_songs; s++) begin
            play_song(s, s == 0);
        end
        if (stalls == 0) begin
            errors++;
            $display("no note ever had to wait for a free voice");
        end
        $display("checks %0d  starts %0d  songs %0d  stalls %0d  errors %0d",
                 checks, starts, dones, stalls, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
hdl/song_pkg.sv
hdl/voice_pkg.sv
hdl/song_ram.sv
hdl/rest_timer.sv
hdl/note_player.sv
hdl/song_sequencer.sv
hdl/song_player_top.sv
bench/tb_song_player.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it into sim.log and judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f all.f --top-module tb_song_player \
    -Mdir obj_dir -o sim_song_player
./obj_dir/sim_song_player > sim.log 2>&1
cat sim.log

if grep -q "^Regression passed$" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
